//--- flist.f
source/axi_mem_pkg.sv
source/mem_port_if.sv
source/congestion_gate.sv
source/axi_write_engine.sv
source/axi_read_engine.sv
source/mem_bank.sv
source/axi_mem_top.sv
dv/tb_axi_mem.sv

//--- run.sh
#!/bin/sh
# compile and run the AXI memory slave testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f flist.f --top-module tb_axi_mem -o sim_tb_axi_mem
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

out=$(./obj_dir/sim_tb_axi_mem)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Finished with no errors"; then
  exit 0
fi
exit 1

//--- dv/tb_axi_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem;
  import axi_mem_pkg::*;

  localparam int NUM_BURSTS     = 200;
  localparam int PRELOAD_BURSTS = (1 << WORD_AW) / 16;   // 16 beats each
  localparam int STALL_FACTOR   = 8;
  localparam int CYCLE_LIMIT    = (NUM_BURSTS + PRELOAD_BURSTS) * 16 * STALL_FACTOR;

  logic              clk, rstn;
  logic [ID_W-1:0]   aw_id, ar_id, b_id, r_id;
  logic [ADDR_W-1:0] aw_addr, ar_addr;
  logic [LEN_W-1:0]  aw_len, ar_len;
  logic [1:0]        aw_burst, ar_burst, b_resp, r_resp;
  logic              aw_valid, aw_ready, w_last, w_valid, w_ready;
  logic              b_valid, b_ready, ar_valid, ar_ready;
  logic              r_last, r_valid, r_ready;
  logic [DATA_W-1:0] w_data, r_data;
  logic [STRB_W-1:0] w_strb;

  logic [DATA_W-1:0] model [int];   // word index -> expected contents
  logic [31:0]       rng_state = 32'hbebb290d;
  int                errors = 0;
  int                cycles = 0;

  axi_mem_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic write_burst(input logic [1:0] burst, input logic [ID_W-1:0] id,
                             input logic [WORD_AW-1:0] start, input int len, input bit full);
    logic [WORD_AW-1:0] idx;
    logic [DATA_W-1:0]  word;
    logic               bad;
    int                 thresh;
    bit                 done;
    bad    = burst == BURST_WRAP || burst == 2'b11;
    idx    = start;
    thresh = 64 + int'(xorshift32() % 192);   // b_ready duty for this burst
    @(negedge clk);
    b_ready  = 1'b0;
    aw_id    = id;
    aw_addr  = {start, 2'b00};
    aw_len   = LEN_W'(len);
    aw_burst = burst;
    aw_valid = 1'b1;
    while (!aw_ready) @(negedge clk);
    for (int beat = 0; beat <= len; beat++) begin
      @(negedge clk);
      aw_valid = 1'b0;
      w_data   = xorshift32();
      w_strb   = full ? '1 : STRB_W'(xorshift32());
      w_last   = beat == len;
      w_valid  = 1'b1;
      while (!w_ready) begin
        assert (!b_valid) else begin
          errors++;
          $display("b_valid rose at %0t before all write beats were sent", $time);
        end
        @(negedge clk);
      end
      if (!bad) begin
        word = model.exists(int'(idx)) ? model[int'(idx)] : '0;
        for (int b = 0; b < STRB_W; b++) begin
          if (w_strb[b]) word[b*8 +: 8] = w_data[b*8 +: 8];
        end
        model[int'(idx)] = word;
      end
      if (burst == BURST_INCR) idx = idx + 1'b1;   // wraps at end of memory
    end
    @(negedge clk);
    w_valid = 1'b0;
    w_last  = 1'b0;
    done    = 1'b0;
    while (!done) begin
      b_ready = xorshift32() % 256 < thresh;
      if (b_valid) begin
        check_val("b_id", 32'(id), 32'(b_id));
        check_val("b_resp", bad ? 32'(RESP_SLVERR) : 32'(RESP_OKAY), 32'(b_resp));
        done = b_ready;
      end
      if (!done) @(negedge clk);
    end
  endtask

  task automatic read_burst(input logic [1:0] burst, input logic [ID_W-1:0] id,
                            input logic [WORD_AW-1:0] start, input int len);
    logic [WORD_AW-1:0] idx;
    logic [DATA_W-1:0]  exp_data;
    logic               bad;
    int                 thresh;
    int                 beat;
    bad    = burst == BURST_WRAP || burst == 2'b11;
    idx    = start;
    beat   = 0;
    thresh = 64 + int'(xorshift32() % 192);
    @(negedge clk);
    r_ready  = 1'b0;
    ar_id    = id;
    ar_addr  = {start, 2'b00};
    ar_len   = LEN_W'(len);
    ar_burst = burst;
    ar_valid = 1'b1;
    while (!ar_ready) @(negedge clk);
    @(negedge clk);
    ar_valid = 1'b0;
    while (beat <= len) begin
      r_ready = xorshift32() % 256 < thresh;
      // checked on every visible cycle, so a held beat must not change
      if (r_valid) begin
        exp_data = bad ? '0 : model[int'(idx)];
        check_val("r_id", 32'(id), 32'(r_id));
        check_val("r_resp", bad ? 32'(RESP_SLVERR) : 32'(RESP_OKAY), 32'(r_resp));
        check_val("r_data", exp_data, r_data);
        check_val("r_last", 32'(beat == len), 32'(r_last));
        if (r_ready) begin
          beat++;
          if (burst == BURST_INCR) idx = idx + 1'b1;
        end
      end
      if (beat <= len) @(negedge clk);
    end
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the run hung waiting on a handshake", cycles);
      $display("errors: %0d", errors);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    logic [31:0] r;
    logic [1:0]  burst;
    rstn     = 1'b0;
    aw_id    = '0;
    aw_addr  = '0;
    aw_len   = '0;
    aw_burst = BURST_INCR;
    aw_valid = 1'b0;
    w_data   = '0;
    w_strb   = '0;
    w_last   = 1'b0;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    ar_id    = '0;
    ar_addr  = '0;
    ar_len   = '0;
    ar_burst = BURST_INCR;
    ar_valid = 1'b0;
    r_ready  = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;

    // full-strobe preload so every word has a known value
    for (int k = 0; k < PRELOAD_BURSTS; k++) begin
      write_burst(BURST_INCR, ID_W'(k), WORD_AW'(k * 16), 15, 1'b1);
    end

    for (int n = 0; n < NUM_BURSTS; n++) begin
      r = xorshift32();
      case (r[2:0])
        3'd4, 3'd5: burst = BURST_FIXED;
        3'd6:       burst = BURST_WRAP;
        3'd7:       burst = 2'b11;   // reserved
        default:    burst = BURST_INCR;
      endcase
      if (r[31]) write_burst(burst, r[7:4], r[17:8], int'(r[21:18]), 1'b0);
      else read_burst(burst, r[7:4], r[17:8], int'(r[21:18]));
    end

    repeat (4) @(negedge clk);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/axi_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_top (
  input  logic                             clk,
  input  logic                             rstn,
  input  logic [axi_mem_pkg::ID_W-1:0]     aw_id,
  input  logic [axi_mem_pkg::ADDR_W-1:0]   aw_addr,
  input  logic [axi_mem_pkg::LEN_W-1:0]    aw_len,
  input  logic [1:0]                       aw_burst,
  input  logic                             aw_valid,
  output logic                             aw_ready,
  input  logic [axi_mem_pkg::DATA_W-1:0]   w_data,
  input  logic [axi_mem_pkg::STRB_W-1:0]   w_strb,
  input  logic                             w_last,
  input  logic                             w_valid,
  output logic                             w_ready,
  output logic [axi_mem_pkg::ID_W-1:0]     b_id,
  output logic [1:0]                       b_resp,
  output logic                             b_valid,
  input  logic                             b_ready,
  input  logic [axi_mem_pkg::ID_W-1:0]     ar_id,
  input  logic [axi_mem_pkg::ADDR_W-1:0]   ar_addr,
  input  logic [axi_mem_pkg::LEN_W-1:0]    ar_len,
  input  logic [1:0]                       ar_burst,
  input  logic                             ar_valid,
  output logic                             ar_ready,
  output logic [axi_mem_pkg::ID_W-1:0]     r_id,
  output logic [axi_mem_pkg::DATA_W-1:0]   r_data,
  output logic [1:0]                       r_resp,
  output logic                             r_last,
  output logic                             r_valid,
  input  logic                             r_ready
);
  import axi_mem_pkg::*;

  logic [CH_COUNT-1:0] open_mask;

  mem_port_if wr_if ();
  mem_port_if rd_if ();

  congestion_gate u_gate (
    .clk       (clk),
    .rstn      (rstn),
    .open_mask (open_mask)
  );

  axi_write_engine u_wr (
    .clk       (clk),
    .rstn      (rstn),
    .open_mask (open_mask),
    .aw_id     (aw_id),
    .aw_addr   (aw_addr),
    .aw_len    (aw_len),
    .aw_burst  (aw_burst),
    .aw_valid  (aw_valid),
    .aw_ready  (aw_ready),
    .w_data    (w_data),
    .w_strb    (w_strb),
    .w_last    (w_last),
    .w_valid   (w_valid),
    .w_ready   (w_ready),
    .b_id      (b_id),
    .b_resp    (b_resp),
    .b_valid   (b_valid),
    .b_ready   (b_ready),
    .mem       (wr_if.engine)
  );

  axi_read_engine u_rd (
    .clk       (clk),
    .rstn      (rstn),
    .open_mask (open_mask),
    .ar_id     (ar_id),
    .ar_addr   (ar_addr),
    .ar_len    (ar_len),
    .ar_burst  (ar_burst),
    .ar_valid  (ar_valid),
    .ar_ready  (ar_ready),
    .r_id      (r_id),
    .r_data    (r_data),
    .r_resp    (r_resp),
    .r_last    (r_last),
    .r_valid   (r_valid),
    .r_ready   (r_ready),
    .mem       (rd_if.engine)
  );

  mem_bank u_bank (
    .clk     (clk),
    .wr_port (wr_if.bank),
    .rd_port (rd_if.bank)
  );

endmodule

`default_nettype wire

//--- source/mem_bank.sv
`timescale 1ns/1ps
`default_nettype none

module mem_bank (
  input  logic       clk,
  mem_port_if.bank   wr_port,
  mem_port_if.bank   rd_port
);
  import axi_mem_pkg::*;

  localparam int DEPTH = 1 << WORD_AW;

  logic [DATA_W-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_port.en && wr_port.we) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wr_port.wstrb[b]) mem[wr_port.word_addr][b*8 +: 8] <= wr_port.wdata[b*8 +: 8];
      end
    end
  end

  // registered read, holds until the next read strobe
  always_ff @(posedge clk) begin
    if (rd_port.en && !rd_port.we) begin
      rd_port.rdata <= mem[rd_port.word_addr];
    end
  end

  assign wr_port.rdata = '0;   // write side never reads back

endmodule

`default_nettype wire

//--- source/axi_read_engine.sv
`timescale 1ns/1ps
`default_nettype none

module axi_read_engine (
  input  logic                               clk,
  input  logic                               rstn,
  input  logic [axi_mem_pkg::CH_COUNT-1:0]   open_mask,
  input  logic [axi_mem_pkg::ID_W-1:0]       ar_id,
  input  logic [axi_mem_pkg::ADDR_W-1:0]     ar_addr,
  input  logic [axi_mem_pkg::LEN_W-1:0]      ar_len,
  input  logic [1:0]                         ar_burst,
  input  logic                               ar_valid,
  output logic                               ar_ready,
  output logic [axi_mem_pkg::ID_W-1:0]       r_id,
  output logic [axi_mem_pkg::DATA_W-1:0]     r_data,
  output logic [1:0]                         r_resp,
  output logic                               r_last,
  output logic                               r_valid,
  input  logic                               r_ready,
  mem_port_if.engine                         mem
);
  import axi_mem_pkg::*;

  logic               ar_phase, issue, r_phase;
  logic [ID_W-1:0]    id_q;
  logic [WORD_AW-1:0] word_idx, idx_next;
  logic [3:0]         beats_left;
  logic               fixed_q;
  logic               bad_q;
  logic               ar_hs, r_hs;

  assign ar_ready = ar_phase & open_mask[CH_AR];
  assign r_valid  = r_phase & open_mask[CH_R];
  assign ar_hs    = ar_ready & ar_valid;
  assign r_hs     = r_valid & r_ready;
  assign idx_next = fixed_q ? word_idx : word_idx + 1'b1;

  assign r_id   = id_q;
  assign r_data = bad_q ? '0 : mem.rdata;
  assign r_resp = bad_q ? RESP_SLVERR : RESP_OKAY;
  assign r_last = beats_left == 4'd0;

  // first beat right after AR, then one read per accepted beat
  assign mem.en        = issue | (r_hs & ~r_last);
  assign mem.we        = 1'b0;
  assign mem.word_addr = issue ? word_idx : idx_next;
  assign mem.wdata     = '0;
  assign mem.wstrb     = '0;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ar_phase <= 1'b0;
      issue    <= 1'b0;
      r_phase  <= 1'b0;
    end else begin
      if (!ar_phase && !issue && !r_phase) ar_phase <= 1'b1;
      if (ar_hs) begin
        ar_phase <= 1'b0;
        issue    <= 1'b1;
      end
      if (issue) begin
        issue   <= 1'b0;
        r_phase <= 1'b1;
      end
      if (r_hs && r_last) begin
        r_phase  <= 1'b0;
        ar_phase <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      id_q       <= ar_id;
      word_idx   <= ar_addr[ADDR_W-1 -: WORD_AW];
      beats_left <= ar_len[3:0];
      fixed_q    <= ar_burst == BURST_FIXED;
      bad_q      <= !(ar_burst == BURST_FIXED || ar_burst == BURST_INCR);
    end else if (r_hs) begin
      beats_left <= beats_left - 4'd1;
      word_idx   <= idx_next;
    end
  end

  // bank output must hold while the master keeps the beat waiting
  r_held_stable: assert property (@(posedge clk) disable iff (!rstn)
    r_valid && !r_ready |=> $stable(r_data) && $stable(r_last))
    else $error("axi_read_engine: R payload changed while held");

endmodule

`default_nettype wire

//--- source/axi_write_engine.sv
`timescale 1ns/1ps
`default_nettype none

module axi_write_engine (
  input  logic                               clk,
  input  logic                               rstn,
  input  logic [axi_mem_pkg::CH_COUNT-1:0]   open_mask,
  input  logic [axi_mem_pkg::ID_W-1:0]       aw_id,
  input  logic [axi_mem_pkg::ADDR_W-1:0]     aw_addr,
  input  logic [axi_mem_pkg::LEN_W-1:0]      aw_len,
  input  logic [1:0]                         aw_burst,
  input  logic                               aw_valid,
  output logic                               aw_ready,
  input  logic [axi_mem_pkg::DATA_W-1:0]     w_data,
  input  logic [axi_mem_pkg::STRB_W-1:0]     w_strb,
  input  logic                               w_last,
  input  logic                               w_valid,
  output logic                               w_ready,
  output logic [axi_mem_pkg::ID_W-1:0]       b_id,
  output logic [1:0]                         b_resp,
  output logic                               b_valid,
  input  logic                               b_ready,
  mem_port_if.engine                         mem
);
  import axi_mem_pkg::*;

  logic               aw_phase, w_phase, b_phase;   // one-hot, all low only out of reset
  logic [ID_W-1:0]    id_q;
  logic [WORD_AW-1:0] word_idx;
  logic [3:0]         beats_left;
  logic               fixed_q;
  logic               bad_q;
  logic               aw_hs, w_hs, b_hs;
  logic               last_beat;

  assign aw_ready  = aw_phase & open_mask[CH_AW];
  assign w_ready   = w_phase & open_mask[CH_W];
  assign b_valid   = b_phase & open_mask[CH_B];
  assign aw_hs     = aw_ready & aw_valid;
  assign w_hs      = w_ready & w_valid;
  assign b_hs      = b_valid & b_ready;
  assign last_beat = beats_left == 4'd0;

  assign b_id   = id_q;
  assign b_resp = bad_q ? RESP_SLVERR : RESP_OKAY;

  // error bursts are accepted beat by beat but never reach memory
  assign mem.en        = w_hs & ~bad_q;
  assign mem.we        = 1'b1;
  assign mem.word_addr = word_idx;
  assign mem.wdata     = w_data;
  assign mem.wstrb     = w_strb;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      aw_phase <= 1'b0;
      w_phase  <= 1'b0;
      b_phase  <= 1'b0;
    end else begin
      if (!aw_phase && !w_phase && !b_phase) aw_phase <= 1'b1;
      if (aw_hs) begin
        aw_phase <= 1'b0;
        w_phase  <= 1'b1;
      end
      if (w_hs && last_beat) begin
        w_phase <= 1'b0;
        b_phase <= 1'b1;
      end
      if (b_hs) begin
        b_phase  <= 1'b0;
        aw_phase <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      id_q       <= aw_id;
      word_idx   <= aw_addr[ADDR_W-1 -: WORD_AW];
      beats_left <= aw_len[3:0];
      fixed_q    <= aw_burst == BURST_FIXED;
      bad_q      <= !(aw_burst == BURST_FIXED || aw_burst == BURST_INCR);
    end else if (w_hs) begin
      beats_left <= beats_left - 4'd1;
      if (!fixed_q) word_idx <= word_idx + 1'b1;   // wraps at memory size
    end
  end

  w_last_matches: assert property (@(posedge clk) disable iff (!rstn)
    w_hs |-> w_last == last_beat)
    else $error("axi_write_engine: w_last disagrees with aw_len");

endmodule

`default_nettype wire

//--- source/congestion_gate.sv
`timescale 1ns/1ps
`default_nettype none

module congestion_gate (
  input  logic                               clk,
  input  logic                               rstn,
  output logic [axi_mem_pkg::CH_COUNT-1:0]   open_mask
);
  import axi_mem_pkg::*;

  logic [15:0]         lfsr;
  logic [31:0]         lfsr_dbl;
  logic [CH_COUNT-1:0] open_next;

  // doubled copy so each channel can take its own rotation
  assign lfsr_dbl = {lfsr, lfsr};

  always_comb begin
    for (int ch = 0; ch < CH_COUNT; ch++) begin
      open_next[ch] = lfsr_dbl[ch*3 +: 8] >= STALL_LEVEL;   // low slice closes the channel
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lfsr      <= LFSR_SEED;
      open_mask <= '1;
    end else begin
      // galois form, x^16 + x^14 + x^13 + x^11 + 1
      lfsr      <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hb400 : 16'h0000);
      open_mask <= open_next;
    end
  end

  // a zero state would lock every channel open or closed for good
  lfsr_nonzero: assert property (@(posedge clk) disable iff (!rstn) lfsr != 16'h0000)
    else $error("congestion_gate: lfsr reached zero");

endmodule

`default_nettype wire

//--- source/mem_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if;
  import axi_mem_pkg::*;

  logic               en;
  logic               we;         // write when high
  logic [WORD_AW-1:0] word_addr;
  logic [DATA_W-1:0]  wdata;
  logic [STRB_W-1:0]  wstrb;
  logic [DATA_W-1:0]  rdata;      // valid the cycle after a read strobe

  modport engine (
    output en,
    output we,
    output word_addr,
    output wdata,
    output wstrb,
    input  rdata
  );

  modport bank (
    input  en,
    input  we,
    input  word_addr,
    input  wdata,
    input  wstrb,
    output rdata
  );

endinterface

`default_nettype wire

//--- source/axi_mem_pkg.sv
`default_nettype none

package axi_mem_pkg;

  localparam int DATA_W  = 32;
  localparam int STRB_W  = DATA_W / 8;
  localparam int ADDR_W  = 12;               // byte address
  localparam int WORD_AW = ADDR_W - 2;       // word index, addr[11:2]
  localparam int ID_W    = 4;
  localparam int LEN_W   = 8;                // only 0..15 legal here

  localparam logic [1:0] BURST_FIXED = 2'b00;
  localparam logic [1:0] BURST_INCR  = 2'b01;
  localparam logic [1:0] BURST_WRAP  = 2'b10;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // stall generator, roughly a quarter of cycles closed per channel
  localparam logic [15:0] LFSR_SEED   = 16'hace1;
  localparam logic [7:0]  STALL_LEVEL = 8'd64;

  localparam int CH_AW    = 0;
  localparam int CH_W     = 1;
  localparam int CH_B     = 2;
  localparam int CH_AR    = 3;
  localparam int CH_R     = 4;
  localparam int CH_COUNT = 5;

endpackage

`default_nettype wire
